// File: design/uart_pkg.sv
//////////////////////////////////////////////////
// Shared widths, reset values and encodings of the
// UART controller, referenced by scoped name from
// every design unit
//////////////////////////////////////////////////

package uart_pkg;

  // Data path widths
  localparam int DATA_W = 8;   // UART character
  localparam int BUS_W  = 32;  // Register bus data
  localparam int ADR_W  = 6;   // Register byte address
  localparam int BDR_W  = 8;   // Baud divisor and sample phase

  // FIFO geometry
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_W      = 4;  // Wraps exactly at FIFO_DEPTH
  localparam int CNT_W      = 5;  // Holds 0..FIFO_DEPTH
  localparam int IDX_W      = 3;  // Bit index within a character

  // Configuration after reset
  localparam logic [BDR_W-1:0] TX_BDR_RST = 8'd15;
  localparam logic [BDR_W-1:0] RX_BDR_RST = 8'd15;
  localparam logic [BDR_W-1:0] RX_SMP_RST = 8'd7;   // Roughly mid-bit
  localparam logic [CNT_W-1:0] TX_IRQ_RST = '0;
  localparam logic [CNT_W-1:0] RX_IRQ_RST = '0;

  // Register map, byte addresses
  typedef enum logic [ADR_W-1:0] {
    REG_TX_DAT = 6'h00,  // Write only, pushes TX FIFO
    REG_TX_CNT = 6'h04,  // Read only
    REG_TX_BDR = 6'h08,
    REG_TX_IRQ = 6'h10,
    REG_RX_DAT = 6'h20,  // Read only, pops RX FIFO
    REG_RX_CNT = 6'h24,  // Read only
    REG_RX_BDR = 6'h28,
    REG_RX_SMP = 6'h2C,
    REG_RX_IRQ = 6'h30
  } uart_reg_e;

  // Serializer FSM
  typedef enum logic [1:0] {SER_IDLE, SER_START, SER_DATA, SER_STOP} ser_state_e;

  // Deserializer FSM
  typedef enum logic [1:0] {DES_IDLE, DES_START, DES_DATA, DES_STOP} des_state_e;

endpackage

// File: design/uart_stream_if.sv
//////////////////////////////////////////////////
// Byte stream with valid/ready handshake plus the
// occupancy of the FIFO on the far side. One
// instance sits on each side of each FIFO
//////////////////////////////////////////////////

interface uart_stream_if;

  logic                        vld;  // Byte offered
  logic [uart_pkg::DATA_W-1:0] dat;  // Byte value
  logic                        rdy;  // Byte accepted
  logic [uart_pkg::CNT_W-1:0]  lvl;  // FIFO occupancy, always driven by the FIFO

  // FIFO write side
  modport fifo_in (input vld, input dat, output rdy, output lvl);

  // FIFO read side
  modport fifo_out (output vld, output dat, output lvl, input rdy);

  // Upstream of a FIFO
  modport prod (output vld, output dat, input rdy, input lvl);

  // Downstream of a FIFO
  modport cons (input vld, input dat, input lvl, output rdy);

endinterface

// File: design/uart_regs.sv
//////////////////////////////////////////////////
// Register block on the single-cycle bus. Holds the
// baud, sample and interrupt settings, pushes TX
// bytes and pops RX bytes in the transfer cycle
//////////////////////////////////////////////////

module uart_regs (
  input  logic                         tcb,
  input  logic                         rst,
  // Register bus
  input  logic                         bus_vld,
  input  logic                         bus_wen,
  input  logic [uart_pkg::ADR_W-1:0]   bus_adr,
  input  logic [uart_pkg::BUS_W-1:0]   bus_wdt,
  output logic [uart_pkg::BUS_W-1:0]   bus_rdt,
  output logic                         bus_rdy,
  // FIFO streams
  uart_stream_if.prod                  tx,
  uart_stream_if.cons                  rx,
  // Configuration to the serial engines
  output logic [uart_pkg::BDR_W-1:0]   tx_bdr,
  output logic [uart_pkg::BDR_W-1:0]   rx_bdr,
  output logic [uart_pkg::BDR_W-1:0]   rx_smp,
  // Interrupts
  output logic                         irq_tx,
  output logic                         irq_rx
);

  uart_pkg::uart_reg_e          adr;     // Decoded address
  logic [uart_pkg::CNT_W-1:0]   tx_irq;  // TX level threshold
  logic [uart_pkg::CNT_W-1:0]   rx_irq;  // RX level threshold

  assign adr     = uart_pkg::uart_reg_e'(bus_adr);
  assign bus_rdy = 1'b1;  // Never stalls

  //////////////////////////////////////////////////
  // Configuration registers

  always_ff @(posedge tcb) begin
    if (rst) begin
      tx_bdr <= uart_pkg::TX_BDR_RST;
      tx_irq <= uart_pkg::TX_IRQ_RST;
      rx_bdr <= uart_pkg::RX_BDR_RST;
      rx_smp <= uart_pkg::RX_SMP_RST;
      rx_irq <= uart_pkg::RX_IRQ_RST;
    end else if (bus_vld && bus_wen) begin
      case (adr)  // Upper data bits dropped
        uart_pkg::REG_TX_BDR: tx_bdr <= bus_wdt[uart_pkg::BDR_W-1:0];
        uart_pkg::REG_TX_IRQ: tx_irq <= bus_wdt[uart_pkg::CNT_W-1:0];
        uart_pkg::REG_RX_BDR: rx_bdr <= bus_wdt[uart_pkg::BDR_W-1:0];
        uart_pkg::REG_RX_SMP: rx_smp <= bus_wdt[uart_pkg::BDR_W-1:0];
        uart_pkg::REG_RX_IRQ: rx_irq <= bus_wdt[uart_pkg::CNT_W-1:0];
        default: ;  // Data, counts and holes
      endcase
    end
  end

  //////////////////////////////////////////////////
  // FIFO access

  // Push on TX_DAT write, lost if the FIFO is full
  assign tx.vld = bus_vld && bus_wen && (adr == uart_pkg::REG_TX_DAT);
  assign tx.dat = bus_wdt[uart_pkg::DATA_W-1:0];

  // Pop on RX_DAT read, no effect while empty
  assign rx.rdy = bus_vld && !bus_wen && (adr == uart_pkg::REG_RX_DAT);

  // Read mux, same cycle
  always_comb begin
    bus_rdt = '0;  // Write-only and unmapped read zero
    case (adr)
      uart_pkg::REG_TX_CNT: bus_rdt[uart_pkg::CNT_W-1:0] = tx.lvl;
      uart_pkg::REG_TX_BDR: bus_rdt[uart_pkg::BDR_W-1:0] = tx_bdr;
      uart_pkg::REG_TX_IRQ: bus_rdt[uart_pkg::CNT_W-1:0] = tx_irq;
      uart_pkg::REG_RX_DAT: begin
        if (rx.vld) bus_rdt[uart_pkg::DATA_W-1:0] = rx.dat;  // Head byte
      end
      uart_pkg::REG_RX_CNT: bus_rdt[uart_pkg::CNT_W-1:0] = rx.lvl;
      uart_pkg::REG_RX_BDR: bus_rdt[uart_pkg::BDR_W-1:0] = rx_bdr;
      uart_pkg::REG_RX_SMP: bus_rdt[uart_pkg::BDR_W-1:0] = rx_smp;
      uart_pkg::REG_RX_IRQ: bus_rdt[uart_pkg::CNT_W-1:0] = rx_irq;
      default: ;
    endcase
  end

  // Level interrupts
  assign irq_tx = (tx.lvl < tx_irq);  // TX running low
  assign irq_rx = (rx.lvl > rx_irq);  // RX filling up

  // Bus never waits on either FIFO
  a_bus_rdy: assert property (@(posedge tcb) disable iff (rst) bus_rdy);

endmodule

// File: design/uart_fifo.sv
//////////////////////////////////////////////////
// Synchronous circular FIFO, valid/ready on both
// sides, occupancy shown on both streams
//////////////////////////////////////////////////

module uart_fifo (
  input  logic           tcb,
  input  logic           rst,
  uart_stream_if.fifo_in  wr,
  uart_stream_if.fifo_out rd
);

  logic [uart_pkg::DATA_W-1:0] mem [uart_pkg::FIFO_DEPTH];
  logic [uart_pkg::PTR_W-1:0]  wr_ptr;  // Next free slot
  logic [uart_pkg::PTR_W-1:0]  rd_ptr;  // Head slot
  logic [uart_pkg::CNT_W-1:0]  cnt;     // Occupancy
  logic                        push;
  logic                        pop;

  assign wr.rdy = (cnt != uart_pkg::FIFO_DEPTH);  // Low only when full
  assign rd.vld = (cnt != 0);
  assign rd.dat = mem[rd_ptr];
  assign wr.lvl = cnt;
  assign rd.lvl = cnt;

  assign push = wr.vld && wr.rdy;
  assign pop  = rd.vld && rd.rdy;

  // Storage
  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= wr.dat;
  end

  // Pointers and count, pointers wrap at the depth
  always_ff @(posedge tcb) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;  // Idle or both, level unchanged
      endcase
    end
  end

  // Occupancy bound
  a_cnt_max: assert property (@(posedge tcb) disable iff (rst)
    cnt <= uart_pkg::FIFO_DEPTH);

  // Nothing offered while empty
  a_no_vld_empty: assert property (@(posedge tcb) disable iff (rst)
    (cnt == 0) |-> !rd.vld);

endmodule

// File: design/uart_ser.sv
//////////////////////////////////////////////////
// Transmit serializer. Takes one byte from the TX
// FIFO while idle and sends start, 8 data bits LSB
// first and stop, each bit cfg_bdr+1 clocks long
//////////////////////////////////////////////////

module uart_ser (
  input  logic                       tcb,
  input  logic                       rst,
  input  logic [uart_pkg::BDR_W-1:0] cfg_bdr,
  uart_stream_if.cons                str,
  output logic                       txd
);

  uart_pkg::ser_state_e        state;
  logic [uart_pkg::BDR_W-1:0]  cnt;  // Clocks into the current bit
  logic [uart_pkg::IDX_W-1:0]  idx;  // Data bit on the line
  logic [uart_pkg::DATA_W-1:0] sr;   // Bits still to send
  logic                        bit_end;

  assign str.rdy = (state == uart_pkg::SER_IDLE);
  assign bit_end = (cnt == cfg_bdr);

  // Shift register, payload only
  always_ff @(posedge tcb) begin
    if (str.vld && str.rdy) begin
      sr <= str.dat;
    end else if (bit_end && (state == uart_pkg::SER_DATA)) begin
      sr <= sr >> 1;  // Next bit to the LSB
    end
  end

  //////////////////////////////////////////////////
  // Frame FSM

  always_ff @(posedge tcb) begin
    if (rst) begin
      state <= uart_pkg::SER_IDLE;
      cnt   <= '0;
      idx   <= '0;
      txd   <= 1'b1;  // Line idles high
    end else begin
      cnt <= (bit_end || state == uart_pkg::SER_IDLE) ? '0 : cnt + 1'b1;
      case (state)
        uart_pkg::SER_IDLE: if (str.vld) begin
          state <= uart_pkg::SER_START;
          txd   <= 1'b0;  // Start bit
        end
        uart_pkg::SER_START: if (bit_end) begin
          state <= uart_pkg::SER_DATA;
          idx   <= '0;
          txd   <= sr[0];
        end
        uart_pkg::SER_DATA: if (bit_end) begin
          idx <= idx + 1'b1;
          if (&idx) begin  // Last data bit done
            state <= uart_pkg::SER_STOP;
            txd   <= 1'b1;
          end else begin
            txd <= sr[1];  // sr shifts on this edge
          end
        end
        uart_pkg::SER_STOP: if (bit_end) state <= uart_pkg::SER_IDLE;
        default: state <= uart_pkg::SER_IDLE;
      endcase
    end
  end

  // Line is marking whenever no frame is in progress
  a_idle_high: assert property (@(posedge tcb) disable iff (rst)
    (state == uart_pkg::SER_IDLE) |-> txd);

endmodule

// File: design/uart_des.sv
//////////////////////////////////////////////////
// Receive deserializer. Synchronizes rxd, detects
// the start edge, rechecks it at the sample phase
// and collects 8 bits plus stop at the divisor rate
//////////////////////////////////////////////////

module uart_des (
  input  logic                       tcb,
  input  logic                       rst,
  input  logic [uart_pkg::BDR_W-1:0] cfg_bdr,
  input  logic [uart_pkg::BDR_W-1:0] cfg_smp,
  input  logic                       rxd,
  uart_stream_if.prod                str
);

  uart_pkg::des_state_e        state;
  logic [1:0]                  sync;    // Two-flop synchronizer
  logic                        rxd_q;   // Previous synced sample
  logic                        fall;    // Falling edge on the line
  logic [uart_pkg::BDR_W-1:0]  cnt;     // Clocks since last sample point
  logic [uart_pkg::IDX_W-1:0]  idx;     // Data bit being collected
  logic [uart_pkg::DATA_W-1:0] sr;      // Collected bits
  logic                        vld;

  assign fall    = rxd_q && !sync[1];
  assign str.vld = vld;
  assign str.dat = sr;

  // Line synchronizer, idles high
  always_ff @(posedge tcb) begin
    if (rst) begin
      sync  <= 2'b11;
      rxd_q <= 1'b1;
    end else begin
      sync  <= {sync[0], rxd};
      rxd_q <= sync[1];
    end
  end

  //////////////////////////////////////////////////
  // Frame FSM

  always_ff @(posedge tcb) begin
    if (rst) begin
      state <= uart_pkg::DES_IDLE;
      cnt   <= '0;
      idx   <= '0;
      vld   <= 1'b0;
    end else begin
      vld <= 1'b0;  // Single cycle pulse
      cnt <= cnt + 1'b1;
      case (state)
        uart_pkg::DES_IDLE: begin
          cnt <= '0;
          if (fall) state <= uart_pkg::DES_START;
        end
        uart_pkg::DES_START: if (cnt == cfg_smp) begin
          cnt <= '0;
          idx <= '0;
          // Glitch if the line is back high
          state <= sync[1] ? uart_pkg::DES_IDLE : uart_pkg::DES_DATA;
        end
        uart_pkg::DES_DATA: if (cnt == cfg_bdr) begin
          cnt <= '0;
          idx <= idx + 1'b1;
          if (&idx) state <= uart_pkg::DES_STOP;
        end
        uart_pkg::DES_STOP: if (cnt == cfg_bdr) begin
          state <= uart_pkg::DES_IDLE;
          vld   <= sync[1];  // Framing error drops the byte
        end
        default: state <= uart_pkg::DES_IDLE;
      endcase
    end
  end

  // Data bits enter at the MSB, LSB arrives first
  always_ff @(posedge tcb) begin
    if (state == uart_pkg::DES_DATA && cnt == cfg_bdr) sr <= {sync[1], sr[7:1]};
  end

  // One byte per frame, frames are far longer than a cycle
  a_vld_pulse: assert property (@(posedge tcb) disable iff (rst)
    str.vld |=> !str.vld);

endmodule

// File: design/uart_ctl.sv
//////////////////////////////////////////////////
// UART controller top. Register bus and serial
// lines as plain ports, FIFOs and serial engines
// joined by byte stream interfaces
//////////////////////////////////////////////////

module uart_ctl (
  input  logic                       tcb,
  input  logic                       rst,
  // Register bus
  input  logic                       bus_vld,
  input  logic                       bus_wen,
  input  logic [uart_pkg::ADR_W-1:0] bus_adr,
  input  logic [uart_pkg::BUS_W-1:0] bus_wdt,
  output logic [uart_pkg::BUS_W-1:0] bus_rdt,
  output logic                       bus_rdy,
  // Serial lines
  input  logic                       uart_rxd,
  output logic                       uart_txd,
  // Interrupts
  output logic                       irq_tx,
  output logic                       irq_rx
);

  logic [uart_pkg::BDR_W-1:0] tx_bdr;
  logic [uart_pkg::BDR_W-1:0] rx_bdr;
  logic [uart_pkg::BDR_W-1:0] rx_smp;

  uart_stream_if tx_wr ();  // Regs to TX FIFO
  uart_stream_if tx_rd ();  // TX FIFO to serializer
  uart_stream_if rx_wr ();  // Deserializer to RX FIFO
  uart_stream_if rx_rd ();  // RX FIFO to regs

  //////////////////////////////////////////////////
  // Register block

  uart_regs regs (
    .tcb, .rst,
    .bus_vld, .bus_wen, .bus_adr, .bus_wdt, .bus_rdt, .bus_rdy,
    .tx     (tx_wr),
    .rx     (rx_rd),
    .tx_bdr, .rx_bdr, .rx_smp,
    .irq_tx, .irq_rx
  );

  //////////////////////////////////////////////////
  // Transmit path

  uart_fifo tx_fifo (.tcb, .rst, .wr (tx_wr), .rd (tx_rd));

  uart_ser ser (.tcb, .rst, .cfg_bdr (tx_bdr), .str (tx_rd), .txd (uart_txd));

  //////////////////////////////////////////////////
  // Receive path

  uart_des des (
    .tcb, .rst,
    .cfg_bdr (rx_bdr),
    .cfg_smp (rx_smp),
    .rxd     (uart_rxd),
    .str     (rx_wr)
  );

  uart_fifo rx_fifo (.tcb, .rst, .wr (rx_wr), .rd (rx_rd));

endmodule

// File: tb/tb_uart_ctl.sv
//////////////////////////////////////////////////
// Testbench of the UART controller. Drives the
// register bus, decodes uart_txd and feeds uart_rxd
// from a line driver or in loopback
//////////////////////////////////////////////////

module tb_uart_ctl;

  logic                       tcb;
  logic                       rst;
  logic                       bus_vld;
  logic                       bus_wen;
  logic [uart_pkg::ADR_W-1:0] bus_adr;
  logic [uart_pkg::BUS_W-1:0] bus_wdt;
  logic [uart_pkg::BUS_W-1:0] bus_rdt;
  logic                       bus_rdy;
  logic                       uart_rxd;
  logic                       uart_txd;
  logic                       irq_tx;
  logic                       irq_rx;

  logic        drv_line;    // Line driver output
  logic        loopback;    // uart_rxd taken from uart_txd
  logic        chk_rdt;     // Compare bus_rdt this cycle
  logic [31:0] exp_rdt;
  logic [31:0] rdt;         // Last value read
  logic [31:0] seed;
  logic [7:0]  tx_q [$];    // Bytes due on uart_txd
  logic [7:0]  rx_q [$];    // Bytes due in the RX FIFO
  logic [7:0]  tx_bdr_sh;   // Configured values as written
  logic [7:0]  rx_bdr_sh;
  logic [4:0]  tx_irq_sh;
  logic [4:0]  rx_irq_sh;
  logic        rd_tx_cnt;
  logic        rd_rx_cnt;
  int          errors;
  int          n_wr;        // TX_DAT writes, dropped ones too
  int          n_dec;       // Frames decoded off uart_txd
  int          n_rx;        // Bytes popped from RX_DAT

  assign uart_rxd  = loopback ? uart_txd : drv_line;
  assign rd_tx_cnt = bus_vld && !bus_wen && (bus_adr == uart_pkg::REG_TX_CNT);
  assign rd_rx_cnt = bus_vld && !bus_wen && (bus_adr == uart_pkg::REG_RX_CNT);

  uart_ctl DUT (.*);

  initial begin
    tcb = 1'b0;
    forever #50 tcb = ~tcb;
  end

  //////////////////////////////////////////////////
  // Checks

  a_rst: assert property (@(posedge tcb) $fell(rst) |-> (uart_txd && !irq_tx && !irq_rx))
    else begin
      errors++;
      $display("Mismatch uart_txd/irq_tx/irq_rx: got %h/%h/%h expected 1/0/0",
               $sampled(uart_txd), $sampled(irq_tx), $sampled(irq_rx));
    end

  // Every transfer completes in its own cycle
  a_rdy: assert property (@(posedge tcb) disable iff (rst) bus_vld |-> bus_rdy)
    else begin
      errors++;
      $display("Mismatch bus_rdy: got %h expected 1", $sampled(bus_rdy));
    end

  a_rdt: assert property (@(posedge tcb) disable iff (rst) chk_rdt |-> bus_rdt == exp_rdt)
    else begin
      errors++;
      $display("Mismatch bus_rdt at %h: got %h expected %h",
               $sampled(bus_adr), $sampled(bus_rdt), $sampled(exp_rdt));
    end

  // Level bounded by bytes not yet on the line and by the depth
  a_tx_cnt: assert property (@(posedge tcb) disable iff (rst)
    rd_tx_cnt |-> (bus_rdt <= n_wr - n_dec && bus_rdt <= uart_pkg::FIFO_DEPTH))
    else begin
      errors++;
      $display("Mismatch TX_CNT: got %h limit %h", $sampled(bus_rdt), $sampled(n_wr - n_dec));
    end

  a_irq_tx: assert property (@(posedge tcb) disable iff (rst)
    rd_tx_cnt |-> irq_tx == (bus_rdt < tx_irq_sh))
    else begin
      errors++;
      $display("Mismatch irq_tx: got %h expected %h", $sampled(irq_tx), !$sampled(irq_tx));
    end

  a_irq_rx: assert property (@(posedge tcb) disable iff (rst)
    rd_rx_cnt |-> irq_rx == (bus_rdt > rx_irq_sh))
    else begin
      errors++;
      $display("Mismatch irq_rx: got %h expected %h", $sampled(irq_rx), !$sampled(irq_rx));
    end

  //////////////////////////////////////////////////
  // Bus and line tasks

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic tick;
    @(posedge tcb);
    #10;
  endtask

  // One transfer, entered and left 10 units after an edge
  task automatic bus_op(input logic wen, input logic [uart_pkg::ADR_W-1:0] adr,
                        input logic [31:0] wdt, input logic chk, input logic [31:0] exp);
    bus_vld = 1'b1;
    bus_wen = wen;
    bus_adr = adr;
    bus_wdt = wdt;
    chk_rdt = chk;
    exp_rdt = exp;
    #80;
    rdt = bus_rdt;  // Settled before the edge
    tick;
    bus_vld = 1'b0;
    chk_rdt = 1'b0;
  endtask

  task automatic reg_write(input logic [uart_pkg::ADR_W-1:0] adr, input logic [31:0] wdt);
    bus_op(1'b1, adr, wdt, 1'b0, '0);
  endtask

  task automatic reg_read(input logic [uart_pkg::ADR_W-1:0] adr);
    bus_op(1'b0, adr, '0, 1'b0, '0);
  endtask

  task automatic reg_check(input logic [uart_pkg::ADR_W-1:0] adr, input logic [31:0] exp);
    bus_op(1'b0, adr, '0, 1'b1, exp);
  endtask

  // Writes all five settings, reads them back truncated
  task automatic set_cfg(input logic [31:0] bdr_t, input logic [31:0] irq_t,
                         input logic [31:0] bdr_r, input logic [31:0] smp_r,
                         input logic [31:0] irq_r);
    reg_write(uart_pkg::REG_TX_BDR, bdr_t);
    reg_write(uart_pkg::REG_TX_IRQ, irq_t);
    reg_write(uart_pkg::REG_RX_BDR, bdr_r);
    reg_write(uart_pkg::REG_RX_SMP, smp_r);
    reg_write(uart_pkg::REG_RX_IRQ, irq_r);
    tx_bdr_sh = bdr_t[7:0];
    tx_irq_sh = irq_t[4:0];
    rx_bdr_sh = bdr_r[7:0];
    rx_irq_sh = irq_r[4:0];
    reg_check(uart_pkg::REG_TX_BDR, tx_bdr_sh);
    reg_check(uart_pkg::REG_TX_IRQ, tx_irq_sh);
    reg_check(uart_pkg::REG_RX_BDR, rx_bdr_sh);
    reg_check(uart_pkg::REG_RX_SMP, smp_r[7:0]);
    reg_check(uart_pkg::REG_RX_IRQ, rx_irq_sh);
  endtask

  // Polls a count register until it reads n
  task automatic wait_level(input logic [uart_pkg::ADR_W-1:0] adr, input int n);
    int t;
    for (t = 0; t < 4000; t++) begin
      reg_read(adr);
      if (rdt == n) break;
    end
    if (t == 4000) begin
      errors++;
      $display("Timeout waiting for level %0d at register %h", n, adr);
    end
  endtask

  // Random bytes to TX_DAT, first keep ones expected on the line
  task automatic write_tx(input int n, input int keep, input logic to_rx);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      seed = xorshift(seed);
      b = seed[7:0];
      if (i < keep) tx_q.push_back(b);
      if (to_rx) rx_q.push_back(b);
      n_wr++;
      reg_write(uart_pkg::REG_TX_DAT, b);
      reg_read(uart_pkg::REG_TX_CNT);
    end
  endtask

  // Frame on uart_rxd at the RX bit time
  task automatic send_frame(input logic [7:0] b, input logic stop);
    logic [9:0] f;
    f = {stop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      drv_line = f[i];
      repeat (rx_bdr_sh + 1) tick;
    end
    drv_line = 1'b1;
  endtask

  task automatic send_rx(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      seed = xorshift(seed);
      b = seed[7:0];
      rx_q.push_back(b);
      send_frame(b, 1'b1);
    end
  endtask

  task automatic drain_rx;
    while (rx_q.size() > 0) begin
      reg_check(uart_pkg::REG_RX_DAT, rx_q.pop_front());
      n_rx++;
      reg_check(uart_pkg::REG_RX_CNT, rx_q.size());
    end
    reg_check(uart_pkg::REG_RX_DAT, 0);  // Empty FIFO reads zero
  endtask

  // Samples uart_txd mid-bit on falling clock edges
  task automatic decode_frames(input int n);
    logic [9:0] f;
    logic [7:0] exp;
    int bt;
    int t;
    bt = tx_bdr_sh + 1;
    for (int k = 0; k < n; k++) begin
      t = 0;
      do begin
        @(negedge tcb);
        t++;
      end while (uart_txd && t < 30 * bt);
      if (uart_txd) begin
        errors++;
        $display("Timeout waiting for a start bit on uart_txd");
        return;
      end
      repeat (bt / 2) @(negedge tcb);  // Middle of start bit
      f[0] = uart_txd;
      for (int i = 1; i < 10; i++) begin
        repeat (bt) @(negedge tcb);
        f[i] = uart_txd;
      end
      n_dec++;
      assert (!f[0] && f[9]) else begin
        errors++;
        $display("Bad start or stop bit on uart_txd");
      end
      if (tx_q.size() == 0) begin
        errors++;
        $display("Frame on uart_txd that was never written");
      end else begin
        exp = tx_q.pop_front();
        assert (f[8:1] == exp) else begin
          errors++;
          $display("Mismatch uart_txd data: got %h expected %h", f[8:1], exp);
        end
      end
    end
  endtask

  task automatic expect_line_idle(input int cycles);
    int t;
    for (t = 0; t < cycles; t++) begin
      @(negedge tcb);
      if (!uart_txd) break;
    end
    assert (t == cycles) else begin
      errors++;
      $display("A dropped byte started a frame on uart_txd");
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence

  initial begin
    rst      = 1'b1;
    bus_vld  = 1'b0;
    bus_wen  = 1'b0;
    bus_adr  = '0;
    bus_wdt  = '0;
    drv_line = 1'b1;  // Idle mark
    loopback = 1'b0;
    chk_rdt  = 1'b0;
    exp_rdt  = '0;
    seed     = 32'hb149;
    errors   = 0;
    n_wr     = 0;
    n_dec    = 0;
    n_rx     = 0;
    tx_bdr_sh = uart_pkg::TX_BDR_RST;
    rx_bdr_sh = uart_pkg::RX_BDR_RST;
    tx_irq_sh = uart_pkg::TX_IRQ_RST;
    rx_irq_sh = uart_pkg::RX_IRQ_RST;
    repeat (10) @(posedge tcb);
    #10;
    rst = 1'b0;

    reg_check(uart_pkg::REG_TX_CNT, 0);
    reg_check(uart_pkg::REG_RX_CNT, 0);
    reg_check(uart_pkg::REG_TX_BDR, uart_pkg::TX_BDR_RST);
    reg_check(uart_pkg::REG_TX_IRQ, uart_pkg::TX_IRQ_RST);
    reg_check(uart_pkg::REG_RX_BDR, uart_pkg::RX_BDR_RST);
    reg_check(uart_pkg::REG_RX_SMP, uart_pkg::RX_SMP_RST);
    reg_check(uart_pkg::REG_RX_IRQ, uart_pkg::RX_IRQ_RST);

    // Wide writes, read-only and unmapped addresses
    set_cfg(32'hffff_ff5a, 32'hffff_fff3, 32'h1234_56a5, 32'h0000_0133, 32'h0000_00ee);
    reg_write(uart_pkg::REG_TX_CNT, 32'h1f);
    reg_write(uart_pkg::REG_RX_DAT, 32'h55);
    reg_write(6'h0c, 32'hffff_ffff);
    reg_check(uart_pkg::REG_TX_CNT, 0);
    reg_check(uart_pkg::REG_RX_DAT, 0);
    reg_check(uart_pkg::REG_TX_DAT, 0);  // Write only
    reg_check(6'h0c, 0);
    reg_check(6'h3c, 0);

    // Transmit, TX level rises past 2 and drains
    set_cfg(3, 2, 15, 7, 0);
    fork
      begin
        write_tx(6, 6, 1'b0);
        wait_level(uart_pkg::REG_TX_CNT, 0);
      end
      decode_frames(6);
    join
    tick;

    // Receive from the driver, bad stop bit in between
    set_cfg(3, 2, 9, 4, 1);
    send_rx(3);
    wait_level(uart_pkg::REG_RX_CNT, 3);
    send_frame(8'hc3, 1'b0);
    repeat (rx_bdr_sh + 1) tick;  // Mark again before the next start edge
    send_rx(1);
    wait_level(uart_pkg::REG_RX_CNT, 4);
    drain_rx;

    // Loopback at matching rates
    set_cfg(7, 0, 7, 3, 0);
    loopback = 1'b1;
    fork
      begin
        write_tx(3, 3, 1'b1);
        wait_level(uart_pkg::REG_RX_CNT, 3);
      end
      decode_frames(3);
    join
    tick;
    drain_rx;
    loopback = 1'b0;

    // Overflow, one byte in the serializer plus a full FIFO
    set_cfg(255, 0, 15, 7, 0);
    fork
      write_tx(uart_pkg::FIFO_DEPTH + 4, uart_pkg::FIFO_DEPTH + 1, 1'b0);
      begin
        decode_frames(uart_pkg::FIFO_DEPTH + 1);
        expect_line_idle(3 * 10 * 256);
      end
    join
    tick;

    $display("Errors: %0d, frames decoded: %0d, bytes read: %0d", errors, n_dec, n_rx);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: uart_ctl.f
design/uart_pkg.sv
design/uart_stream_if.sv
design/uart_regs.sv
design/uart_fifo.sv
design/uart_ser.sv
design/uart_des.sv
design/uart_ctl.sv
tb/tb_uart_ctl.sv

// File: Bender.yml
package:
  name: uart_ctl

sources:
  - design/uart_pkg.sv
  - design/uart_stream_if.sv
  - design/uart_regs.sv
  - design/uart_fifo.sv
  - design/uart_ser.sv
  - design/uart_des.sv
  - design/uart_ctl.sv
  - target: test
    files:
      - tb/tb_uart_ctl.sv
